// File: rtl/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;

    // ALU operations, then branch compares
    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SUB  = 4'b0001;
    localparam alu_op_t ALU_AND  = 4'b0010;
    localparam alu_op_t ALU_OR   = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SLL  = 4'b0101;
    localparam alu_op_t ALU_SRL  = 4'b0110;
    localparam alu_op_t ALU_SRA  = 4'b0111;
    localparam alu_op_t ALU_SLT  = 4'b1000;
    localparam alu_op_t ALU_SLTU = 4'b1001;
    localparam alu_op_t BR_BEQ   = 4'b1010;
    localparam alu_op_t BR_BNE   = 4'b1011;
    localparam alu_op_t BR_BLT   = 4'b1100;
    localparam alu_op_t BR_BGE   = 4'b1101;
    localparam alu_op_t BR_BLTU  = 4'b1110;
    localparam alu_op_t BR_BGEU  = 4'b1111;

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef struct packed {
        alu_op_t alu_op;
        logic    op2_imm;   // Operand 2 from immediate
        logic    mem_wen;
        logic    rf_wen;
        logic    wb_mem;    // Writeback from load data
        logic    is_branch;
        logic    illegal;   // Outside subset, runs as no-op
    } ctrl_t;

endpackage

// File: rtl/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  rv_pkg::word_t    instr_i,
    output rv_pkg::ctrl_t    ctrl_o,
    output rv_pkg::reg_idx_t rs1_o,
    output rv_pkg::reg_idx_t rs2_o,
    output rv_pkg::reg_idx_t rd_o,
    output rv_pkg::word_t    imm_o
);
    import rv_pkg::*;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // sub and sra

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;

    function automatic ctrl_t mk_ctrl(alu_op_t op, logic use_imm, logic st, logic wr,
                                      logic from_mem, logic br);
        ctrl_t c;
        c.alu_op    = op;
        c.op2_imm   = use_imm;
        c.mem_wen   = st;
        c.rf_wen    = wr;
        c.wb_mem    = from_mem;
        c.is_branch = br;
        c.illegal   = 1'b0;
        return c;
    endfunction

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];
    assign rd_o   = instr_i[11:7];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};

    assign imm_o = (opcode == OPC_STORE)  ? imm_s :
                   (opcode == OPC_BRANCH) ? imm_b : imm_i;

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.illegal = 1'b1;
        case (opcode)
            OPC_LOAD: if (funct3 == 3'b010) ctrl_o = mk_ctrl(ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
            OPC_STORE: if (funct3 == 3'b010) ctrl_o = mk_ctrl(ALU_ADD, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
            OPC_OP: begin
                case ({funct7, funct3})
                    {F7_BASE, 3'b000}: ctrl_o = mk_ctrl(ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_ALT,  3'b000}: ctrl_o = mk_ctrl(ALU_SUB, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b001}: ctrl_o = mk_ctrl(ALU_SLL, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b010}: ctrl_o = mk_ctrl(ALU_SLT, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b011}: ctrl_o = mk_ctrl(ALU_SLTU, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b100}: ctrl_o = mk_ctrl(ALU_XOR, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b101}: ctrl_o = mk_ctrl(ALU_SRL, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_ALT,  3'b101}: ctrl_o = mk_ctrl(ALU_SRA, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b110}: ctrl_o = mk_ctrl(ALU_OR, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    {F7_BASE, 3'b111}: ctrl_o = mk_ctrl(ALU_AND, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
                    default: ;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: ctrl_o = mk_ctrl(ALU_ADD, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b010: ctrl_o = mk_ctrl(ALU_SLT, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b011: ctrl_o = mk_ctrl(ALU_SLTU, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b100: ctrl_o = mk_ctrl(ALU_XOR, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b110: ctrl_o = mk_ctrl(ALU_OR, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b111: ctrl_o = mk_ctrl(ALU_AND, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b001: if (funct7 == F7_BASE) ctrl_o = mk_ctrl(ALU_SLL, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    3'b101: begin
                        // Shift type lives in the upper immediate bits
                        if (funct7 == F7_BASE)
                            ctrl_o = mk_ctrl(ALU_SRL, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                        else if (funct7 == F7_ALT)
                            ctrl_o = mk_ctrl(ALU_SRA, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
                    end
                    default: ;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000: ctrl_o = mk_ctrl(BR_BEQ, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    3'b001: ctrl_o = mk_ctrl(BR_BNE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    3'b100: ctrl_o = mk_ctrl(BR_BLT, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    3'b101: ctrl_o = mk_ctrl(BR_BGE, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    3'b110: ctrl_o = mk_ctrl(BR_BLTU, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    3'b111: ctrl_o = mk_ctrl(BR_BGEU, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             we_i,
    input  rv_pkg::reg_idx_t waddr_i,
    input  rv_pkg::word_t    wdata_i,
    input  rv_pkg::reg_idx_t raddr1_i,
    input  rv_pkg::reg_idx_t raddr2_i,
    output rv_pkg::word_t    rdata1_o,
    output rv_pkg::word_t    rdata2_o
);
    import rv_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin   // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

    // A write must name a known register inside the file
    assert property (@(posedge clk) disable iff (!rst_n)
        we_i |-> (!$isunknown(waddr_i) && int'(waddr_i) < 32))
        else $error("regfile write to bad index %0d", waddr_i);

endmodule

// File: rtl/rv_alu.sv
`timescale 1ns/1ns

module rv_alu (
    input  rv_pkg::alu_op_t op_i,
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    output rv_pkg::word_t   result_o,
    output logic            br_taken_o
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);
            ALU_SLT:  result_o = {31'b0, lt_s};
            ALU_SLTU: result_o = {31'b0, lt_u};
            default:  result_o = '0;   // Branch codes
        endcase
    end

    always_comb begin
        case (op_i)
            BR_BEQ:  br_taken_o = (a_i == b_i);
            BR_BNE:  br_taken_o = (a_i != b_i);
            BR_BLT:  br_taken_o = lt_s;
            BR_BGE:  br_taken_o = !lt_s;
            BR_BLTU: br_taken_o = lt_u;
            BR_BGEU: br_taken_o = !lt_u;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

// File: rtl/rv_core.sv
`timescale 1ns/1ns

module rv_core #(
    parameter rv_pkg::word_t EXIT_ADDR = 32'h0000_0100
) (
    input  logic          clk,
    input  logic          rst_n,
    output rv_pkg::word_t imem_addr_o,
    input  rv_pkg::word_t instr_i,
    output rv_pkg::word_t dmem_addr_o,
    output rv_pkg::word_t dmem_wdata_o,
    output logic          dmem_wen_o,
    input  rv_pkg::word_t dmem_rdata_i,
    output logic          exit_o
);
    import rv_pkg::*;

    word_t    pc_q;
    word_t    pc_next;
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    op2;
    word_t    alu_result;
    logic     br_taken;
    word_t    wb_data;
    logic     run;

    rv_decoder i_decoder (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .rd_o    (rd),
        .imm_o   (imm)
    );

    rv_regfile i_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .we_i     (ctrl.rf_wen && run),
        .waddr_i  (rd),
        .wdata_i  (wb_data),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign op2 = ctrl.op2_imm ? imm : rs2_data;

    rv_alu i_alu (
        .op_i       (ctrl.alu_op),
        .a_i        (rs1_data),
        .b_i        (op2),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    assign exit_o = (pc_q == EXIT_ADDR);
    assign run    = rst_n && !exit_o;   // Load port owns memory in reset

    assign pc_next = (ctrl.is_branch && br_taken) ? pc_q + imm : pc_q + 32'd4;
    assign wb_data = ctrl.wb_mem ? dmem_rdata_i : alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o  = pc_q;
    assign dmem_addr_o  = alu_result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_wen_o   = ctrl.mem_wen && run;

    assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00)
        else $error("pc misaligned: %h", pc_q);

endmodule

// File: rtl/rv_memory.sv
`timescale 1ns/1ns

module rv_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  rv_pkg::word_t                iaddr_i,
    output rv_pkg::word_t                idata_o,
    input  rv_pkg::word_t                daddr_i,
    input  rv_pkg::word_t                dwdata_i,
    input  logic                         dwen_i,
    output rv_pkg::word_t                drdata_o,
    input  logic                         load_we_i,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr_i,
    input  rv_pkg::word_t                load_data_i,
    input  logic                         rst_n
);
    import rv_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    word_t         mem [MEM_WORDS];
    logic [AW-1:0] iidx;
    logic [AW-1:0] didx;
    logic [AW-1:0] widx;
    logic          we;
    word_t         wdata;

    // Byte address to word index, wraps at the depth
    assign iidx = iaddr_i[AW+1:2];
    assign didx = daddr_i[AW+1:2];

    assign idata_o  = mem[iidx];
    assign drdata_o = mem[didx];

    always_comb begin
        if (!rst_n) begin
            we    = load_we_i;
            widx  = load_addr_i;
            wdata = load_data_i;
        end else begin
            we    = dwen_i;
            widx  = didx;
            wdata = dwdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (we) mem[widx] <= wdata;
    end

    assert property (@(posedge clk) rst_n |-> !load_we_i)
        else $error("load port written outside reset");

endmodule

// File: rtl/rv_top.sv
`timescale 1ns/1ns

module rv_top #(
    parameter int            MEM_WORDS = 256,
    parameter rv_pkg::word_t EXIT_ADDR = 32'h0000_0100
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         load_we_i,
    input  logic [$clog2(MEM_WORDS)-1:0] load_addr_i,
    input  rv_pkg::word_t                load_data_i,
    output logic                         exit_o,
    output rv_pkg::word_t                pc_o,
    output logic                         st_valid_o,
    output rv_pkg::word_t                st_addr_o,
    output rv_pkg::word_t                st_data_o
);
    import rv_pkg::*;

    word_t instr;
    word_t dmem_rdata;

    // Store trace is the data write bus itself
    rv_core #(
        .EXIT_ADDR (EXIT_ADDR)
    ) i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (pc_o),
        .instr_i      (instr),
        .dmem_addr_o  (st_addr_o),
        .dmem_wdata_o (st_data_o),
        .dmem_wen_o   (st_valid_o),
        .dmem_rdata_i (dmem_rdata),
        .exit_o       (exit_o)
    );

    rv_memory #(
        .MEM_WORDS (MEM_WORDS)
    ) i_memory (
        .clk         (clk),
        .iaddr_i     (pc_o),
        .idata_o     (instr),
        .daddr_i     (st_addr_o),
        .dwdata_i    (st_data_o),
        .dwen_i      (st_valid_o),
        .drdata_o    (dmem_rdata),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .rst_n       (rst_n)
    );

endmodule

// File: dv/tb_rv_programs.svh
`ifndef TB_RV_PROGRAMS_SVH
`define TB_RV_PROGRAMS_SVH

// Indexed by operation kind: add sub and or xor sll srl sra slt sltu
localparam logic [2:0] OP_F3 [10] = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100,
                                      3'b001, 3'b101, 3'b101, 3'b010, 3'b011};
localparam logic [6:0] OP_F7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                      7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
localparam logic [2:0] BR_F3 [6]  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

// addi andi ori xori slli srli srai slti sltiu
localparam int          IMM_KIND [9] = '{0, 2, 3, 4, 5, 6, 7, 8, 9};
localparam logic [11:0] IMM_VAL [9]  = '{12'hb2e, 12'h5a3, 12'hf00, 12'h123, 12'h007,
                                        12'h00d, 12'h409, 12'hf9c, 12'hfff};

function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t enc_i(logic [6:0] opc, logic [11:0] imm, reg_idx_t rs1,
                                logic [2:0] f3, reg_idx_t rd);
    return {imm, rs1, f3, rd, opc};
endfunction

// Stores always use x1 as base
function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2);
    return {imm[11:5], rs2, 5'd1, 3'b010, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_b(logic [12:0] off, reg_idx_t rs1, reg_idx_t rs2,
                                logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
endfunction

task automatic emit(word_t instr);
    load_q.push_back({n_instr[7:0], instr});
    n_instr++;
endtask

task automatic place_data(logic [7:0] idx_off, word_t w);
    load_q.push_back({DATA_BASE[9:2] + idx_off, w});
endtask

task automatic expect_store(word_t value);
    exp_q.push_back({DATA_BASE + {20'd0, st_off}, value});
    st_off += 12'd4;
endtask

task automatic store_reg(reg_idx_t rs2, word_t value);
    emit(enc_s(st_off, rs2));
    expect_store(value);
endtask

task automatic build_program();
    word_t a;
    word_t b;
    word_t p;
    word_t q;
    word_t r;
    // Early store at pc 0 that reset has to mask
    load_q.push_back({8'd0, enc_s(12'h3fc, 5'd0)});
    a = next_random();
    b = next_random();
    place_data(8'd0, a);
    place_data(8'd1, b);
    place_data(8'd2, POISON);
    place_data(8'd3, PASS_MARK);
    emit(enc_i(OPC_OP_IMM, DATA_BASE[11:0], 5'd0, 3'b000, 5'd1));
    emit(enc_i(OPC_LOAD, 12'd0, 5'd1, 3'b010, 5'd3));
    emit(enc_i(OPC_LOAD, 12'd4, 5'd1, 3'b010, 5'd4));
    emit(enc_i(OPC_LOAD, 12'd8, 5'd1, 3'b010, 5'd8));    // Poison marker
    emit(enc_i(OPC_LOAD, 12'd12, 5'd1, 3'b010, 5'd9));   // Pass marker
    for (int k = 0; k < 10; k++) begin
        emit(enc_r(OP_F7[k], 5'd4, 5'd3, OP_F3[k], 5'd5));
        store_reg(5'd5, alu_model(k, a, b));
    end
    for (int k = 0; k < 9; k++) begin
        emit(enc_i(OPC_OP_IMM, IMM_VAL[k], 5'd3, OP_F3[IMM_KIND[k]], 5'd5));
        store_reg(5'd5, alu_model(IMM_KIND[k], a, sext12(IMM_VAL[k])));
    end
    emit(enc_i(OPC_OP_IMM, 12'd55, 5'd3, 3'b000, 5'd0));   // Dropped write to x0
    store_reg(5'd0, '0);
    for (int j = 0; j < 6; j++) begin
        for (int t = 0; t < 2; t++) begin
            do begin
                r = next_random();
                p = sext12(r[11:0]);
                r = next_random();
                q = sext12(r[11:0]);
                if ((j == 0 && t == 1) || (j == 1 && t == 0)) q = p;
            end while (branch_model(j, p, q) != (t == 1));
            emit(enc_i(OPC_OP_IMM, p[11:0], 5'd0, 3'b000, 5'd6));
            emit(enc_i(OPC_OP_IMM, q[11:0], 5'd0, 3'b000, 5'd7));
            emit(enc_b(13'd12, 5'd6, 5'd7, BR_F3[j]));
            emit(enc_s(st_off, (t == 1) ? 5'd8 : 5'd9));   // Fall-through path
            emit(enc_b(13'd8, 5'd0, 5'd0, 3'b000));
            emit(enc_s(st_off, (t == 1) ? 5'd9 : 5'd8));   // Taken path
            expect_store(PASS_MARK);
        end
    end
    load_q.push_back({n_instr[7:0], enc_s(st_off, 5'd8)});   // Poison store at exit address
endtask

`endif

// File: dv/tb_rv_top.sv
`timescale 1ns/1ns

module tb_rv_top;
    import rv_pkg::*;

    typedef struct packed {
        logic [7:0] idx;
        word_t      word;
    } load_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam int    MEM_WORDS  = 256;
    localparam int    PROG_LEN   = 117;
    localparam word_t EXIT_ADDR  = PROG_LEN * 4;
    localparam word_t DATA_BASE  = 32'h0000_0300;
    localparam word_t POISON     = 32'hbad0bad0;
    localparam word_t PASS_MARK  = 32'h600d600d;
    localparam int    MAX_CYCLES = 2 * PROG_LEN + 50;

    logic        clk;
    logic        rst_n;
    logic        load_we;
    logic [7:0]  load_addr;
    word_t       load_data;
    logic        exit_lvl;
    word_t       pc;
    logic        st_valid;
    word_t       st_addr;
    word_t       st_data;

    word_t       rng_state;
    load_t       load_q [$];
    store_t      exp_q [$];
    store_t      exp_head;
    logic        exp_pending;
    logic [11:0] st_off;
    int          n_instr;
    int          cycles;
    int          reset_errs;
    int          store_errs;
    int          marker_errs;
    int          exit_errs;
    int          build_errs;

    rv_top #(
        .MEM_WORDS (MEM_WORDS),
        .EXIT_ADDR (EXIT_ADDR)
    ) i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .exit_o      (exit_lvl),
        .pc_o        (pc),
        .st_valid_o  (st_valid),
        .st_addr_o   (st_addr),
        .st_data_o   (st_data)
    );

    function automatic word_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // Expected result per operation kind, shifts by the low 5 bits
    function automatic word_t alu_model(int kind, word_t a, word_t b);
        case (kind)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            7: return word_t'($signed(a) >>> b[4:0]);
            8: return {31'd0, $signed(a) < $signed(b)};
            default: return {31'd0, a < b};
        endcase
    endfunction

    function automatic logic branch_model(int kind, word_t a, word_t b);
        case (kind)
            0: return a == b;
            1: return a != b;
            2: return $signed(a) < $signed(b);
            3: return $signed(a) >= $signed(b);
            4: return a < b;
            default: return a >= b;
        endcase
    endfunction

    `include "tb_rv_programs.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Head of the store queue, moves on each retired store
    always @(posedge clk) begin
        if (rst_n && st_valid && exp_q.size() > 0) void'(exp_q.pop_front());
        exp_pending <= exp_q.size() > 0;
        exp_head    <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    always @(posedge clk) begin
        if (rst_n) cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: exit was not reached within %0d cycles", MAX_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    assert property (@(posedge clk) !rst_n |=> pc == '0 && !exit_lvl && !st_valid)
        else begin
            reset_errs++;
            $display("Error at %0t ns: pc %h exit %b store %b after a reset cycle",
                     $time, $sampled(pc), $sampled(exit_lvl), $sampled(st_valid));
        end

    assert property (@(posedge clk) !rst_n |-> !st_valid)
        else begin
            reset_errs++;
            $display("Error at %0t ns: store strobe high during reset", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        st_valid |-> exp_pending && st_addr == exp_head.addr && st_data == exp_head.data)
        else begin
            store_errs++;
            $display("Error at %0t ns: store %h <= %h, expected %h <= %h (pending %b)",
                     $time, $sampled(st_addr), $sampled(st_data), $sampled(exp_head.addr),
                     $sampled(exp_head.data), $sampled(exp_pending));
        end

    assert property (@(posedge clk) disable iff (!rst_n) st_valid |-> st_data != POISON)
        else begin
            marker_errs++;
            $display("Error at %0t ns: wrong branch path stored the poison marker", $time);
        end

    assert property (@(posedge clk) disable iff (!rst_n) exit_lvl |=> exit_lvl && $stable(pc))
        else begin
            exit_errs++;
            $display("Error at %0t ns: pc %h moved or exit dropped", $time, $sampled(pc));
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        pc == EXIT_ADDR |-> exit_lvl && !st_valid)
        else begin
            exit_errs++;
            $display("Error at %0t ns: exit low or store active at exit address", $time);
        end

    initial begin
        load_t ld;
        rst_n       = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        rng_state   = 32'h3f497a01;
        exp_pending = 1'b0;
        exp_head    = '0;
        st_off      = 12'h040;
        n_instr     = 0;
        cycles      = 0;
        reset_errs  = 0;
        store_errs  = 0;
        marker_errs = 0;
        exit_errs   = 0;
        build_errs  = 0;
        build_program();
        if (n_instr != PROG_LEN) begin
            build_errs++;
            $display("Program builder made %0d instructions, exit address needs %0d",
                     n_instr, PROG_LEN);
        end
        // Reset covers the whole load, then 8 more cycles
        while (load_q.size() > 0) begin
            @(negedge clk);
            ld        = load_q.pop_front();
            load_we   = 1'b1;
            load_addr = ld.idx;
            load_data = ld.word;
        end
        @(negedge clk);
        load_we = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        while (!exit_lvl) @(negedge clk);
        repeat (5) @(negedge clk);   // Exit must hold
        if (exp_q.size() != 0) begin
            exit_errs++;
            $display("Exit reached with %0d expected stores never seen", exp_q.size());
        end
        $display("Check counts: reset %0d, store %0d, marker %0d, exit %0d, build %0d",
                 reset_errs, store_errs, marker_errs, exit_errs, build_errs);
        if (reset_errs + store_errs + marker_errs + exit_errs + build_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: rv_core.f
+incdir+dv
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_core.sv
rtl/rv_memory.sv
rtl/rv_top.sv
dv/tb_rv_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       ?= tb_rv_top
FILELIST  ?= rv_core.f
LOG       ?= sim.log
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
